//--- Makefile
SIM      = verilator
TOP      = tb_lv_reg_subsys
FILELIST = tb.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only if the simulation printed its pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_lv_reg_subsys.sv
// testbench for lv_reg_subsys, owt link answered by an in-bench responder
// expected values come from a local bank model and an owt target array
`default_nettype none

module tb_lv_reg_subsys;
    import lv_reg_pkg::*;

    localparam int N_LOCAL     = 16;
    localparam int N_OWT       = 8;
    localparam int N_MIX       = 300;
    localparam int NUM_OPS     = 2 * N_LOCAL + 3 * N_OWT + N_MIX + int'(SCAN_LAST) + 1;
    localparam int SWEEP_CYC   = (int'(SCAN_LAST) + 1) * (SCAN_INTERVAL + 8);
    localparam int TIMEOUT_CYC = NUM_OPS * 20 + 4 * SCAN_INTERVAL * 64;

    logic                 i_clk;
    logic                 i_rst_n;
    logic                 i_spi_wr_req;
    logic                 i_spi_rd_req;
    logic [REG_AW-1:0]    i_spi_addr;
    logic [REG_DW-1:0]    i_spi_wdata;
    logic [REG_CRC_W-1:0] i_spi_wcrc;
    logic                 o_spi_wack;
    logic                 o_spi_rack;
    logic [REG_DW-1:0]    o_spi_rdata;
    logic                 o_owt_wr_req;
    logic                 o_owt_rd_req;
    logic [REG_AW-1:0]    o_owt_addr;
    logic [REG_DW-1:0]    o_owt_data;
    logic                 i_owt_wack;
    logic                 i_owt_rack;
    logic [REG_DW-1:0]    i_owt_rdata;
    logic                 o_scan_err;
    logic [REG_AW-1:0]    o_scan_err_addr;

    // reference model state
    logic [REG_DW-1:0]    bank_data [REG_NUM];
    logic [REG_CRC_W-1:0] bank_crc  [REG_NUM];
    logic [REG_DW-1:0]    owt_mem   [REG_NUM];
    logic                 flagged   [REG_NUM];
    logic [15:0]          lfsr      = 16'd45;
    // 0 no scan error allowed, 1 ignored, 2 recorded
    int                   scan_mode = 0;
    string                test_name = "reset";

    lv_reg_subsys UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ============================================================
    // helpers
    // ============================================================
    // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // remainder of data * x^8 divided by x^8 + x^2 + x + 1
    function automatic logic [REG_CRC_W-1:0] crc_ref(input logic [REG_DW-1:0] d);
        logic [REG_DW+7:0] rem;
        rem = {d, 8'h00};
        for (int i = REG_DW + 7; i >= 8; i--) begin
            if (rem[i]) begin
                rem[i -: 9] = rem[i -: 9] ^ 9'h107;
            end
        end
        return rem[7:0];
    endfunction

    function automatic logic owt_route(input logic is_wr, input logic [REG_AW-1:0] a);
        logic hit;
        hit = (a >= HV_ANA_START) && (a <= HV_ANA_END);
        for (int i = 0; i < COM_WR_NUM; i++) begin
            if (is_wr && a == COM_WR_ADDR[i]) begin
                hit = 1'b1;
            end
        end
        for (int i = 0; i < COM_RD_NUM; i++) begin
            if (!is_wr && a == COM_RD_ADDR[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic entry_bad(input logic [REG_AW-1:0] a);
        return bank_crc[a] != crc_ref(bank_data[a]);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_data(input string what, input logic [REG_DW-1:0] exp,
                              input logic [REG_DW-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s %s expected 0x%h actual 0x%h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input logic [REG_AW-1:0] exp,
                              input logic [REG_AW-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s %s expected 0x%h actual 0x%h",
                                    test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERR %s %s expected %b actual %b",
                                    test_name, what, exp, act));
        end
    endtask

    // one spi access, held until acknowledged, checked against the model
    task automatic spi_access(input logic is_wr, input logic [REG_AW-1:0] addr,
                              input logic [REG_DW-1:0] wdata,
                              input logic [REG_CRC_W-1:0] wcrc);
        logic owt;
        logic ack;
        int   n;
        owt = owt_route(is_wr, addr);
        n   = 0;
        @(posedge i_clk);
        i_spi_addr   <= addr;
        i_spi_wdata  <= wdata;
        i_spi_wcrc   <= wcrc;
        i_spi_wr_req <= is_wr;
        i_spi_rd_req <= !is_wr;
        do begin
            @(negedge i_clk);
            n++;
            ack = is_wr ? o_spi_wack : o_spi_rack;
            // local accesses answer two cycles after the rise
            if (!owt) begin
                check_flag("local ack timing", n == 3, ack);
            end
        end while (!ack);
        if (owt) begin
            check_flag("owt request level", 1'b1, is_wr ? o_owt_wr_req : o_owt_rd_req);
            check_flag("owt link ack", 1'b1, is_wr ? i_owt_wack : i_owt_rack);
            check_addr("owt address", addr, o_owt_addr);
            if (is_wr) begin
                check_data("owt write data", wdata, o_owt_data);
            end else begin
                check_data("owt read data", owt_mem[addr], o_spi_rdata);
            end
        end else if (is_wr) begin
            bank_data[addr] = wdata;
            bank_crc[addr]  = wcrc;
        end else begin
            check_data("local read data", bank_data[addr], o_spi_rdata);
        end
        @(posedge i_clk);
        i_spi_wr_req <= 1'b0;
        i_spi_rd_req <= 1'b0;
    endtask

    // ============================================================
    // owt responder, monitor, watchdog
    // ============================================================
    initial begin : owt_responder
        logic [REG_AW-1:0] a;
        logic              w;
        int                dly;
        i_owt_wack  <= 1'b0;
        i_owt_rack  <= 1'b0;
        i_owt_rdata <= '0;
        forever begin
            @(negedge i_clk);
            if (o_owt_wr_req || o_owt_rd_req) begin
                a   = o_owt_addr;
                w   = o_owt_wr_req;
                dly = 1 + int'(rand_bits(3));
                repeat (dly) @(posedge i_clk);
                if (w) begin
                    owt_mem[a] = o_owt_data;
                    i_owt_wack <= 1'b1;
                end else begin
                    i_owt_rdata <= owt_mem[a];
                    i_owt_rack  <= 1'b1;
                end
                @(posedge i_clk);
                i_owt_wack <= 1'b0;
                i_owt_rack <= 1'b0;
            end
        end
    end

    initial begin : event_monitor
        forever begin
            @(negedge i_clk);
            if (o_spi_wack && !i_spi_wr_req) begin
                stop_on_error("write acknowledge arrived with no write request pending");
            end
            if (o_spi_rack && !i_spi_rd_req) begin
                stop_on_error("read acknowledge arrived with no read request pending");
            end
            if (o_scan_err && scan_mode == 0) begin
                check_flag("scan error with all crcs valid", 1'b0, o_scan_err);
            end else if (o_scan_err && scan_mode == 2) begin
                check_flag("scan error on a clean entry", 1'b1, entry_bad(o_scan_err_addr));
                flagged[o_scan_err_addr] = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge i_clk);
        stop_on_error("run timed out before all tests finished");
    end

    // ============================================================
    // test sequence
    // ============================================================
    initial begin : main_seq
        logic [REG_AW-1:0]    a;
        logic [REG_DW-1:0]    d;
        logic [REG_CRC_W-1:0] c;
        logic                 w;
        for (int i = 0; i < REG_NUM; i++) begin
            bank_data[i] = '0;
            bank_crc[i]  = crc_ref('0);
            owt_mem[i]   = {i[6:0], 2'b10, ~i[6:0]};
            flagged[i]   = 1'b0;
        end
        i_rst_n      <= 1'b0;
        i_spi_wr_req <= 1'b0;
        i_spi_rd_req <= 1'b0;
        i_spi_addr   <= '0;
        i_spi_wdata  <= '0;
        i_spi_wcrc   <= '0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_flag("owt wr req after reset", 1'b0, o_owt_wr_req);
        check_flag("owt rd req after reset", 1'b0, o_owt_rd_req);
        check_flag("spi wack after reset", 1'b0, o_spi_wack);
        check_flag("spi rack after reset", 1'b0, o_spi_rack);
        check_flag("scan err after reset", 1'b0, o_scan_err);

        test_name = "local write and read-back";
        for (int i = 0; i < N_LOCAL; i++) begin
            do begin
                a = REG_AW'(rand_bits(REG_AW));
            end while (owt_route(1'b1, a) || owt_route(1'b0, a));
            d = rand_bits(REG_DW);
            spi_access(1'b1, a, d, crc_ref(d));
            spi_access(1'b0, a, '0, '0);
        end

        // read-back shows either an untouched local entry or the owt target
        test_name = "owt write routing";
        for (int i = 0; i < N_OWT; i++) begin
            if (rand_bits(1) == 1) begin
                a = COM_WR_ADDR[rand_bits(3) % COM_WR_NUM];
            end else begin
                a = HV_ANA_START + REG_AW'(rand_bits(5));
            end
            d = rand_bits(REG_DW);
            spi_access(1'b1, a, d, crc_ref(d));
            spi_access(1'b0, a, '0, '0);
        end

        test_name = "owt read routing";
        for (int i = 0; i < N_OWT; i++) begin
            if (rand_bits(1) == 1) begin
                a = COM_RD_ADDR[rand_bits(3) % COM_RD_NUM];
            end else begin
                a = HV_ANA_START + REG_AW'(rand_bits(5));
            end
            spi_access(1'b0, a, '0, '0);
        end

        // mostly local so that kicks stay rare and the scanner keeps running
        test_name = "random mix under scanning";
        for (int i = 0; i < N_MIX; i++) begin
            w = rand_bits(1);
            do begin
                a = REG_AW'(rand_bits(REG_AW));
            end while (owt_route(w, a) && rand_bits(3) != 0);
            d = rand_bits(REG_DW);
            spi_access(w, a, d, crc_ref(d));
            repeat (int'(rand_bits(4))) @(posedge i_clk);
        end

        test_name = "scanner crc check";
        scan_mode = 1;
        for (int i = 0; i <= int'(SCAN_LAST); i++) begin
            d = rand_bits(REG_DW);
            c = crc_ref(d);
            if (rand_bits(2) == 0) begin
                c = c ^ (8'h01 << rand_bits(3));
            end
            spi_access(1'b1, REG_AW'(i), d, c);
        end
        repeat (4) @(posedge i_clk);
        scan_mode = 2;
        repeat (SWEEP_CYC) @(posedge i_clk);
        scan_mode = 1;
        for (int i = 0; i <= int'(SCAN_LAST); i++) begin
            check_flag($sformatf("scan error seen for address 0x%h", i),
                       entry_bad(REG_AW'(i)), flagged[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/lv_reg_ifs.sv
// bundles between the access controller and its datapath blocks
// reg_bus_if enables are single-cycle pulses; owt_cmd_if starts likewise
`default_nettype none

interface reg_bus_if;
    import lv_reg_pkg::*;

    logic                 ren;
    logic                 wen;
    logic [REG_AW-1:0]    addr;
    logic [REG_DW-1:0]    wdata;
    logic [REG_CRC_W-1:0] wcrc;
    logic                 wack;
    logic                 rack;
    logic [REG_DW-1:0]    rdata;
    logic [REG_CRC_W-1:0] rcrc;

    modport master (output ren, wen, addr, wdata, wcrc, input wack, rack, rdata, rcrc);
    modport slave  (input ren, wen, addr, wdata, wcrc, output wack, rack, rdata, rcrc);
endinterface

interface owt_cmd_if;
    import lv_reg_pkg::*;

    logic              start_wr;
    logic              start_rd;
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] data;
    logic              done_wr;
    logic              done_rd;
    logic [REG_DW-1:0] rdata;

    // done arrives a link-dependent number of cycles after start
    modport ctrl (output start_wr, start_rd, addr, data, input done_wr, done_rd, rdata);
    modport port (input start_wr, start_rd, addr, data, output done_wr, done_rd, rdata);
endinterface

`default_nettype wire

//--- rtl/lv_reg_pkg.sv
// shared widths, address map and scan settings for the lv register subsystem
// the crc8 here must match the crc the spi master computes on writes
`default_nettype none

package lv_reg_pkg;

    // ============================================================
    // widths and address map
    // ============================================================
    localparam int REG_AW    = 7;
    localparam int REG_DW    = 16;
    localparam int REG_CRC_W = 8;
    localparam int REG_NUM   = 1 << REG_AW;

    // hv analog window, inclusive on both ends
    localparam logic [REG_AW-1:0] HV_ANA_START = 7'h40;
    localparam logic [REG_AW-1:0] HV_ANA_END   = 7'h6E;

    // common digital registers living on the hv die
    localparam int COM_WR_NUM = 7;
    localparam int COM_RD_NUM = 7;
    localparam logic [REG_AW-1:0] COM_WR_ADDR [COM_WR_NUM] =
        '{7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B};
    localparam logic [REG_AW-1:0] COM_RD_ADDR [COM_RD_NUM] =
        '{7'h08, 7'h0A, 7'h0C, 7'h0D, 7'h14, 7'h15, 7'h1F};

    // ============================================================
    // watchdog scan
    // ============================================================
    localparam logic [REG_AW-1:0] SCAN_LAST = 7'h3F;
    localparam int SCAN_INTERVAL = 64;
    localparam int SCAN_CNT_W    = $clog2(SCAN_INTERVAL);

    typedef enum logic {
        ROUTE_LOCAL,
        ROUTE_OWT
    } acc_route_e;

    typedef enum logic [1:0] {
        SCAN_WAIT,
        SCAN_REQ,
        SCAN_CHECK
    } scan_state_e;

    // crc-8, poly 0x07, init 0, msb first
    function automatic logic [REG_CRC_W-1:0] crc8(input logic [REG_DW-1:0] data);
        logic [REG_CRC_W-1:0] crc;
        logic                 fb;
        crc = '0;
        for (int i = REG_DW - 1; i >= 0; i--) begin
            fb  = crc[REG_CRC_W-1] ^ data[i];
            crc = {crc[REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ 8'h07;
            end
        end
        return crc;
    endfunction

    localparam logic [REG_CRC_W-1:0] RESET_CRC = crc8('0);

endpackage

`default_nettype wire

//--- rtl/lv_reg_subsys.sv
// lv side register access top, spi and owt link modelled as parallel levels
// spi master must drop its request for a cycle between accesses
`default_nettype none

module lv_reg_subsys (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_spi_wr_req,
    input  logic                             i_spi_rd_req,
    input  logic [lv_reg_pkg::REG_AW-1:0]    i_spi_addr,
    input  logic [lv_reg_pkg::REG_DW-1:0]    i_spi_wdata,
    input  logic [lv_reg_pkg::REG_CRC_W-1:0] i_spi_wcrc,
    output logic                             o_spi_wack,
    output logic                             o_spi_rack,
    output logic [lv_reg_pkg::REG_DW-1:0]    o_spi_rdata,
    output logic                             o_owt_wr_req,
    output logic                             o_owt_rd_req,
    output logic [lv_reg_pkg::REG_AW-1:0]    o_owt_addr,
    output logic [lv_reg_pkg::REG_DW-1:0]    o_owt_data,
    input  logic                             i_owt_wack,
    input  logic                             i_owt_rack,
    input  logic [lv_reg_pkg::REG_DW-1:0]    i_owt_rdata,
    output logic                             o_scan_err,
    output logic [lv_reg_pkg::REG_AW-1:0]    o_scan_err_addr
);
    import lv_reg_pkg::*;

    logic                 scan_req;
    logic [REG_AW-1:0]    scan_addr;
    logic                 scan_ack;
    logic [REG_DW-1:0]    scan_data;
    logic [REG_CRC_W-1:0] scan_crc;
    logic                 kick;

    reg_bus_if u_bus ();
    owt_cmd_if u_owt ();

    // ============================================================
    // control
    // ============================================================
    reg_access_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_spi_wr_req (i_spi_wr_req),
        .i_spi_rd_req (i_spi_rd_req),
        .i_spi_addr   (i_spi_addr),
        .i_spi_wdata  (i_spi_wdata),
        .i_spi_wcrc   (i_spi_wcrc),
        .o_spi_wack   (o_spi_wack),
        .o_spi_rack   (o_spi_rack),
        .o_spi_rdata  (o_spi_rdata),
        .i_scan_req   (scan_req),
        .i_scan_addr  (scan_addr),
        .o_scan_ack   (scan_ack),
        .o_scan_data  (scan_data),
        .o_scan_crc   (scan_crc),
        .o_kick       (kick),
        .bus          (u_bus.master),
        .owt          (u_owt.ctrl)
    );

    // ============================================================
    // datapath
    // ============================================================
    reg_bank u_bank (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (u_bus.slave)
    );

    wdg_reg_scan u_scan (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_kick          (kick),
        .i_scan_ack      (scan_ack),
        .i_scan_data     (scan_data),
        .i_scan_crc      (scan_crc),
        .o_scan_req      (scan_req),
        .o_scan_addr     (scan_addr),
        .o_scan_err      (o_scan_err),
        .o_scan_err_addr (o_scan_err_addr)
    );

    owt_access_port u_owt_port (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .owt          (u_owt.port),
        .i_owt_wack   (i_owt_wack),
        .i_owt_rack   (i_owt_rack),
        .i_owt_rdata  (i_owt_rdata),
        .o_owt_wr_req (o_owt_wr_req),
        .o_owt_rd_req (o_owt_rd_req),
        .o_owt_addr   (o_owt_addr),
        .o_owt_data   (o_owt_data)
    );

endmodule

`default_nettype wire

//--- rtl/owt_access_port.sv
// holds owt request levels until the link acknowledges
// acks with no matching request pending are ignored
`default_nettype none

module owt_access_port (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    owt_cmd_if.port                       owt,
    input  logic                          i_owt_wack,
    input  logic                          i_owt_rack,
    input  logic [lv_reg_pkg::REG_DW-1:0] i_owt_rdata,
    output logic                          o_owt_wr_req,
    output logic                          o_owt_rd_req,
    output logic [lv_reg_pkg::REG_AW-1:0] o_owt_addr,
    output logic [lv_reg_pkg::REG_DW-1:0] o_owt_data
);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_owt_wr_req <= 1'b0;
            o_owt_rd_req <= 1'b0;
        end else begin
            if (owt.start_wr) begin
                o_owt_wr_req <= 1'b1;
            end else if (i_owt_wack) begin
                o_owt_wr_req <= 1'b0;
            end
            if (owt.start_rd) begin
                o_owt_rd_req <= 1'b1;
            end else if (i_owt_rack) begin
                o_owt_rd_req <= 1'b0;
            end
        end
    end

    // address and data stay stable while the request is up
    always_ff @(posedge i_clk) begin
        if (owt.start_wr | owt.start_rd) begin
            o_owt_addr <= owt.addr;
        end
        if (owt.start_wr) begin
            o_owt_data <= owt.data;
        end
    end

    assign owt.done_wr = i_owt_wack & o_owt_wr_req;
    assign owt.done_rd = i_owt_rack & o_owt_rd_req;
    assign owt.rdata   = i_owt_rdata;

endmodule

`default_nettype wire

//--- rtl/reg_access_ctrl.sv
// spi requests are levels; only the rising edge launches an access
// local accesses answer 2 cycles after the rise, owt ones when the link acks
`default_nettype none

module reg_access_ctrl (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_spi_wr_req,
    input  logic                             i_spi_rd_req,
    input  logic [lv_reg_pkg::REG_AW-1:0]    i_spi_addr,
    input  logic [lv_reg_pkg::REG_DW-1:0]    i_spi_wdata,
    input  logic [lv_reg_pkg::REG_CRC_W-1:0] i_spi_wcrc,
    output logic                             o_spi_wack,
    output logic                             o_spi_rack,
    output logic [lv_reg_pkg::REG_DW-1:0]    o_spi_rdata,
    input  logic                             i_scan_req,
    input  logic [lv_reg_pkg::REG_AW-1:0]    i_scan_addr,
    output logic                             o_scan_ack,
    output logic [lv_reg_pkg::REG_DW-1:0]    o_scan_data,
    output logic [lv_reg_pkg::REG_CRC_W-1:0] o_scan_crc,
    output logic                             o_kick,
    reg_bus_if.master                        bus,
    owt_cmd_if.ctrl                          owt
);
    import lv_reg_pkg::*;

    logic       spi_wr_q;
    logic       spi_rd_q;
    logic       wr_go;
    logic       rd_go;
    logic       wr_list_hit;
    logic       rd_list_hit;
    logic       ana_hit;
    logic       wr_owt;
    logic       rd_owt;
    logic       scan_grant;
    logic [1:0] grant_q;
    acc_route_e route_q;

    // ============================================================
    // address decode
    // ============================================================
    always_comb begin
        wr_list_hit = 1'b0;
        for (int i = 0; i < COM_WR_NUM; i++) begin
            if (i_spi_addr == COM_WR_ADDR[i]) begin
                wr_list_hit = 1'b1;
            end
        end
    end

    always_comb begin
        rd_list_hit = 1'b0;
        for (int i = 0; i < COM_RD_NUM; i++) begin
            if (i_spi_addr == COM_RD_ADDR[i]) begin
                rd_list_hit = 1'b1;
            end
        end
    end

    assign ana_hit = (i_spi_addr >= HV_ANA_START) && (i_spi_addr <= HV_ANA_END);
    assign wr_owt  = wr_list_hit | ana_hit;
    assign rd_owt  = rd_list_hit | ana_hit;

    // write wins if both rise together
    assign wr_go = i_spi_wr_req & ~spi_wr_q;
    assign rd_go = i_spi_rd_req & ~spi_rd_q & ~wr_go;

    // scanner only when spi is quiet and no grant in the last two cycles
    assign scan_grant = i_scan_req & ~(i_spi_wr_req | i_spi_rd_req) & ~(|grant_q);

    // owt starts are combinational so the port raises its level at edge 1
    assign owt.start_wr = wr_go & wr_owt;
    assign owt.start_rd = rd_go & rd_owt;
    assign owt.addr     = i_spi_addr;
    assign owt.data     = i_spi_wdata;

    // ============================================================
    // launch and grant pipeline
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            spi_wr_q <= 1'b0;
            spi_rd_q <= 1'b0;
            grant_q  <= '0;
            bus.ren  <= 1'b0;
            bus.wen  <= 1'b0;
            o_kick   <= 1'b0;
            route_q  <= ROUTE_LOCAL;
        end else begin
            spi_wr_q <= i_spi_wr_req;
            spi_rd_q <= i_spi_rd_req;
            grant_q  <= {grant_q[0], scan_grant};
            bus.ren  <= (rd_go & ~rd_owt) | scan_grant;
            bus.wen  <= wr_go & ~wr_owt;
            o_kick   <= owt.start_wr | owt.start_rd;
            if (wr_go | rd_go) begin
                route_q <= (wr_go ? wr_owt : rd_owt) ? ROUTE_OWT : ROUTE_LOCAL;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_go | rd_go) begin
            bus.addr <= i_spi_addr;
        end else if (scan_grant) begin
            bus.addr <= i_scan_addr;
        end
        if (wr_go) begin
            bus.wdata <= i_spi_wdata;
            bus.wcrc  <= i_spi_wcrc;
        end
    end

    // rack two cycles after a grant belongs to the scanner
    assign o_scan_ack  = bus.rack & grant_q[1];
    assign o_scan_data = bus.rdata;
    assign o_scan_crc  = bus.rcrc;

    assign o_spi_wack  = (route_q == ROUTE_OWT) ? owt.done_wr : bus.wack;
    assign o_spi_rack  = (route_q == ROUTE_OWT) ? owt.done_rd : (bus.rack & ~grant_q[1]);
    assign o_spi_rdata = (route_q == ROUTE_OWT) ? owt.rdata : bus.rdata;

endmodule

`default_nettype wire

//--- rtl/reg_bank.sv
// local register storage, one data word and one crc byte per address
// crc is stored as written, nothing is checked on the write path
`default_nettype none

module reg_bank (
    input  logic      i_clk,
    input  logic      i_rst_n,
    reg_bus_if.slave  bus
);
    import lv_reg_pkg::*;

    logic [REG_DW-1:0]    data_mem [REG_NUM];
    logic [REG_CRC_W-1:0] crc_mem  [REG_NUM];

    // ============================================================
    // storage and acknowledges
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                data_mem[i] <= '0;
                crc_mem[i]  <= RESET_CRC;
            end
            bus.wack <= 1'b0;
            bus.rack <= 1'b0;
        end else begin
            // one cycle after the enable
            bus.wack <= bus.wen;
            bus.rack <= bus.ren;
            if (bus.wen) begin
                data_mem[bus.addr] <= bus.wdata;
                crc_mem[bus.addr]  <= bus.wcrc;
            end
        end
    end

    // read data, valid alongside rack
    always_ff @(posedge i_clk) begin
        if (bus.ren) begin
            bus.rdata <= data_mem[bus.addr];
            bus.rcrc  <= crc_mem[bus.addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/wdg_reg_scan.sv
// background crc scan of local registers 0 to SCAN_LAST, lowest priority
// a kick only restarts the idle count, an outstanding request stays up
`default_nettype none

module wdg_reg_scan (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_kick,
    input  logic                             i_scan_ack,
    input  logic [lv_reg_pkg::REG_DW-1:0]    i_scan_data,
    input  logic [lv_reg_pkg::REG_CRC_W-1:0] i_scan_crc,
    output logic                             o_scan_req,
    output logic [lv_reg_pkg::REG_AW-1:0]    o_scan_addr,
    output logic                             o_scan_err,
    output logic [lv_reg_pkg::REG_AW-1:0]    o_scan_err_addr
);
    import lv_reg_pkg::*;

    scan_state_e           state;
    logic [SCAN_CNT_W-1:0] cnt;
    logic                  crc_bad;

    assign crc_bad    = crc8(i_scan_data) != i_scan_crc;
    assign o_scan_req = (state == SCAN_REQ);

    // ============================================================
    // interval timer and address walk
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= SCAN_WAIT;
            cnt         <= '0;
            o_scan_addr <= '0;
            o_scan_err  <= 1'b0;
        end else begin
            o_scan_err <= 1'b0;
            case (state)
                SCAN_WAIT: begin
                    if (i_kick) begin
                        cnt <= '0;
                    end else if (cnt == SCAN_CNT_W'(SCAN_INTERVAL - 1)) begin
                        cnt   <= '0;
                        state <= SCAN_REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SCAN_REQ: begin
                    // compare straight off the ack so the error lands next cycle
                    if (i_scan_ack) begin
                        o_scan_err <= crc_bad;
                        state      <= SCAN_CHECK;
                    end
                end
                SCAN_CHECK: begin
                    o_scan_addr <= (o_scan_addr == SCAN_LAST) ? '0 : o_scan_addr + 1'b1;
                    cnt         <= '0;
                    state       <= SCAN_WAIT;
                end
                default: begin
                    state <= SCAN_WAIT;
                end
            endcase
        end
    end

    // address of the failing entry, held until the next mismatch
    always_ff @(posedge i_clk) begin
        if (i_scan_ack && o_scan_req && crc_bad) begin
            o_scan_err_addr <= o_scan_addr;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/lv_reg_pkg.sv
rtl/lv_reg_ifs.sv
rtl/reg_bank.sv
rtl/wdg_reg_scan.sv
rtl/owt_access_port.sv
rtl/reg_access_ctrl.sv
rtl/lv_reg_subsys.sv
dv/tb_lv_reg_subsys.sv
